// File: source/rc5_macros.svh
`ifndef RC5_MACROS_SVH
`define RC5_MACROS_SVH

// Word and block geometry
`define RC5_WORD 32
`define RC5_BLOCK 64
`define RC5_KEY 128
`define RC5_KEY_WORDS 4

// Rotate amount width, log2 of the word size
`define RC5_ROT 5

// Round count and derived key table sizes
`define RC5_ROUNDS 12

// Two round keys per round plus the pre-round pair
`define RC5_TABLE 26

// Three passes over the larger of the two tables
`define RC5_MIX_STEPS 78

////////////////////////////////////////////////////////////////////////////
// Magic constants for w = 32
////////////////////////////////////////////////////////////////////////////

// Odd((e - 2) * 2^32)
`define RC5_P32 32'hB7E15163

// Odd((phi - 1) * 2^32)
`define RC5_Q32 32'h9E3779B9

`endif

// File: source/rc5Pkg.sv
`default_nettype none
`include "rc5_macros.svh"

package rc5Pkg;

    // One block seen as halves, A is the upper word
    typedef struct packed {
        logic [`RC5_WORD-1:0] a;
        logic [`RC5_WORD-1:0] b;
    } halvesT;

    typedef union packed {
        logic [`RC5_BLOCK-1:0] flat;
        halvesT                half;
    } blockT;

    // Controller phases, also drive the datapath operation
    typedef enum logic [2:0] {
        IDLE,
        FILL,
        MIX,
        PRE,
        ROUND,
        POST
    } phaseT;

    function automatic logic [`RC5_WORD-1:0] rotl(input logic [`RC5_WORD-1:0] x,
                                                  input logic [`RC5_ROT-1:0] n);
        logic [2*`RC5_WORD-1:0] dbl;
        dbl = {x, x} << n;
        return dbl[2*`RC5_WORD-1:`RC5_WORD];
    endfunction

    function automatic logic [`RC5_WORD-1:0] rotr(input logic [`RC5_WORD-1:0] x,
                                                  input logic [`RC5_ROT-1:0] n);
        logic [2*`RC5_WORD-1:0] dbl;
        dbl = {x, x} >> n;
        return dbl[`RC5_WORD-1:0];
    endfunction

endpackage

`default_nettype wire

// File: source/stepCounter.sv
`default_nettype none

// Counts steps of the current phase and flags the final one
module stepCounter (
    input  wire        clk,
    input  wire        i_rstN,
    input  wire        i_load,
    input  wire  [6:0] i_limit,
    input  wire        i_step,
    output logic [6:0] o_count,
    output logic       o_last
);

    logic [6:0] count;
    logic [6:0] limit;

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            count <= '0;
            limit <= '0;
        end else if (i_load) begin
            // New phase starts from zero
            count <= '0;
            limit <= i_limit;
        end else if (i_step) begin
            count <= count + 7'd1;
        end
    end

    assign o_count = count;
    assign o_last  = (count == limit);

endmodule

`default_nettype wire

// File: source/rc5Control.sv
`default_nettype none
`include "rc5_macros.svh"

module rc5Control (
    input  wire               clk,
    input  wire               i_rstN,
    input  wire               i_keyLoad,
    input  wire               i_start,
    input  wire               i_decrypt,
    input  wire         [6:0] i_count,
    input  wire               i_last,
    output logic              o_cntLoad,
    output logic        [6:0] o_cntLimit,
    output logic              o_cntStep,
    output logic              o_keyCapture,
    output logic              o_fill,
    output logic              o_mix,
    output logic              o_blockLoad,
    output logic        [3:0] o_pairIndex,
    output rc5Pkg::phaseT     o_phase,
    output logic              o_decrypt,
    output logic              o_done,
    output logic              o_keyReady,
    output logic              o_busy
);

    rc5Pkg::phaseT state;
    logic [6:0]    pairWide;

    ////////////////////////////////////////////////////////////////////////////
    // Request qualification
    ////////////////////////////////////////////////////////////////////////////

    // Key load wins if both arrive together
    assign o_keyCapture = (state == rc5Pkg::IDLE) && i_keyLoad;
    assign o_blockLoad  = (state == rc5Pkg::IDLE) && i_start && o_keyReady && !i_keyLoad;

    assign o_busy  = (state != rc5Pkg::IDLE);
    assign o_phase = state;
    assign o_fill  = (state == rc5Pkg::FILL);
    assign o_mix   = (state == rc5Pkg::MIX);

    assign o_cntStep = (state == rc5Pkg::FILL) || (state == rc5Pkg::MIX) ||
                       (state == rc5Pkg::ROUND);
    assign o_cntLoad = o_keyCapture || ((state == rc5Pkg::FILL) && i_last) ||
                       (state == rc5Pkg::PRE);

    // Limit of the phase that the load is about to start
    always_comb begin
        case (state)
            rc5Pkg::IDLE: o_cntLimit = 7'(`RC5_TABLE - 1);
            rc5Pkg::FILL: o_cntLimit = 7'(`RC5_MIX_STEPS - 1);
            default:      o_cntLimit = 7'(`RC5_ROUNDS - 1);
        endcase
    end

    // Round r runs at count r-1, decryption walks the pairs backwards
    assign pairWide = o_decrypt ? 7'(`RC5_ROUNDS) - i_count : i_count + 7'd1;
    assign o_pairIndex = (state == rc5Pkg::ROUND) ? pairWide[3:0] : 4'd0;

    ////////////////////////////////////////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            state      <= rc5Pkg::IDLE;
            o_keyReady <= 1'b0;
            o_decrypt  <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                rc5Pkg::IDLE: begin
                    if (o_keyCapture) begin
                        state      <= rc5Pkg::FILL;
                        o_keyReady <= 1'b0;
                    end else if (o_blockLoad) begin
                        state     <= rc5Pkg::PRE;
                        o_decrypt <= i_decrypt;
                    end
                end
                rc5Pkg::FILL: begin
                    if (i_last) state <= rc5Pkg::MIX;
                end
                rc5Pkg::MIX: begin
                    if (i_last) begin
                        state      <= rc5Pkg::IDLE;
                        o_keyReady <= 1'b1;
                    end
                end
                rc5Pkg::PRE:   state <= rc5Pkg::ROUND;
                rc5Pkg::ROUND: begin
                    if (i_last) state <= rc5Pkg::POST;
                end
                default: begin
                    // POST finishes the block
                    state  <= rc5Pkg::IDLE;
                    o_done <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/keySchedule.sv
`default_nettype none
`include "rc5_macros.svh"

module keySchedule (
    input  wire                  clk,
    input  wire  [`RC5_KEY-1:0]  i_key,
    input  wire                  i_capture,
    input  wire                  i_fill,
    input  wire                  i_mix,
    input  wire  [3:0]           i_pairIndex,
    output logic [`RC5_WORD-1:0] o_keyEven,
    output logic [`RC5_WORD-1:0] o_keyOdd
);

    // Round key table S and key words L
    logic [`RC5_WORD-1:0] sTable [0:`RC5_TABLE-1];
    logic [`RC5_WORD-1:0] lWords [0:`RC5_KEY_WORDS-1];

    logic [`RC5_WORD-1:0] running;
    logic [4:0]           ptrI;
    logic [1:0]           ptrJ;
    logic [`RC5_WORD-1:0] regA;
    logic [`RC5_WORD-1:0] regB;

    logic [`RC5_WORD-1:0] mixA;
    logic [`RC5_WORD-1:0] mixSum;
    logic [`RC5_WORD-1:0] mixB;
    logic [4:0]           nextI;

    ////////////////////////////////////////////////////////////////////////////
    // One mixing step
    ////////////////////////////////////////////////////////////////////////////

    assign mixA   = rc5Pkg::rotl(sTable[ptrI] + regA + regB, 5'd3);
    assign mixSum = mixA + regB;
    assign mixB   = rc5Pkg::rotl(lWords[ptrJ] + mixSum, mixSum[`RC5_ROT-1:0]);

    // i wraps at the table size, j wraps naturally at four
    assign nextI = (ptrI == 5'(`RC5_TABLE - 1)) ? 5'd0 : ptrI + 5'd1;

    always_ff @(posedge clk) begin
        if (i_capture) begin
            for (int k = 0; k < `RC5_KEY_WORDS; k++) begin
                lWords[k] <= i_key[32*k +: 32];
            end
            running <= `RC5_P32;
            ptrI    <= '0;
            ptrJ    <= '0;
            regA    <= '0;
            regB    <= '0;
        end else if (i_fill) begin
            sTable[ptrI] <= running;
            running      <= running + `RC5_Q32;
            ptrI         <= nextI;
        end else if (i_mix) begin
            // Results feed back into both tables
            sTable[ptrI] <= mixA;
            lWords[ptrJ] <= mixB;
            regA         <= mixA;
            regB         <= mixB;
            ptrI         <= nextI;
            ptrJ         <= ptrJ + 2'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Round key read port
    ////////////////////////////////////////////////////////////////////////////

    assign o_keyEven = sTable[{i_pairIndex, 1'b0}];
    assign o_keyOdd  = sTable[{i_pairIndex, 1'b1}];

endmodule

`default_nettype wire

// File: source/roundDatapath.sv
`default_nettype none
`include "rc5_macros.svh"

module roundDatapath (
    input  wire                   clk,
    input  wire                   i_rstN,
    input  wire  [`RC5_BLOCK-1:0] i_block,
    input  wire                   i_start,
    input  rc5Pkg::phaseT         i_phase,
    input  wire                   i_decrypt,
    input  wire  [`RC5_WORD-1:0]  i_keyEven,
    input  wire  [`RC5_WORD-1:0]  i_keyOdd,
    output logic [`RC5_BLOCK-1:0] o_block
);

    rc5Pkg::blockT state;

    logic [`RC5_WORD-1:0] encA;
    logic [`RC5_WORD-1:0] encB;
    logic [`RC5_WORD-1:0] decA;
    logic [`RC5_WORD-1:0] decB;

    ////////////////////////////////////////////////////////////////////////////
    // Round functions
    ////////////////////////////////////////////////////////////////////////////

    // Forward round, B uses the updated A
    assign encA = rc5Pkg::rotl(state.half.a ^ state.half.b,
                               state.half.b[`RC5_ROT-1:0]) + i_keyEven;
    assign encB = rc5Pkg::rotl(state.half.b ^ encA, encA[`RC5_ROT-1:0]) + i_keyOdd;

    // Inverse round undoes B first, then A with the recovered B
    assign decB = rc5Pkg::rotr(state.half.b - i_keyOdd,
                               state.half.a[`RC5_ROT-1:0]) ^ state.half.a;
    assign decA = rc5Pkg::rotr(state.half.a - i_keyEven, decB[`RC5_ROT-1:0]) ^ decB;

    ////////////////////////////////////////////////////////////////////////////
    // Block register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            state.flat <= '0;
        end else if (i_start) begin
            state.flat <= i_block;
        end else begin
            case (i_phase)
                rc5Pkg::PRE: begin
                    // Key whitening on the way in
                    if (!i_decrypt) begin
                        state.half.a <= state.half.a + i_keyEven;
                        state.half.b <= state.half.b + i_keyOdd;
                    end
                end
                rc5Pkg::ROUND: begin
                    if (i_decrypt) begin
                        state.half.a <= decA;
                        state.half.b <= decB;
                    end else begin
                        state.half.a <= encA;
                        state.half.b <= encB;
                    end
                end
                rc5Pkg::POST: begin
                    // Remove whitening on the way out
                    if (i_decrypt) begin
                        state.half.a <= state.half.a - i_keyEven;
                        state.half.b <= state.half.b - i_keyOdd;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    assign o_block = state.flat;

endmodule

`default_nettype wire

// File: source/rc5Core.sv
`default_nettype none
`include "rc5_macros.svh"

// RC5-32/12/16 core with one shared round per cycle
module rc5Core (
    input  wire                   clk,
    input  wire                   i_rstN,
    input  wire  [`RC5_KEY-1:0]   i_key,
    input  wire                   i_keyLoad,
    input  wire  [`RC5_BLOCK-1:0] i_block,
    input  wire                   i_decrypt,
    input  wire                   i_start,
    output logic [`RC5_BLOCK-1:0] o_block,
    output logic                  o_done,
    output logic                  o_keyReady,
    output logic                  o_busy
);

    logic                 cntLoad;
    logic [6:0]           cntLimit;
    logic                 cntStep;
    logic [6:0]           count;
    logic                 last;
    logic                 keyCapture;
    logic                 fill;
    logic                 mix;
    logic                 blockLoad;
    logic [3:0]           pairIndex;
    rc5Pkg::phaseT        phase;
    logic                 decrypt;
    logic [`RC5_WORD-1:0] keyEven;
    logic [`RC5_WORD-1:0] keyOdd;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    stepCounter counter (
        .clk     (clk),
        .i_rstN  (i_rstN),
        .i_load  (cntLoad),
        .i_limit (cntLimit),
        .i_step  (cntStep),
        .o_count (count),
        .o_last  (last)
    );

    rc5Control control (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_keyLoad    (i_keyLoad),
        .i_start      (i_start),
        .i_decrypt    (i_decrypt),
        .i_count      (count),
        .i_last       (last),
        .o_cntLoad    (cntLoad),
        .o_cntLimit   (cntLimit),
        .o_cntStep    (cntStep),
        .o_keyCapture (keyCapture),
        .o_fill       (fill),
        .o_mix        (mix),
        .o_blockLoad  (blockLoad),
        .o_pairIndex  (pairIndex),
        .o_phase      (phase),
        .o_decrypt    (decrypt),
        .o_done       (o_done),
        .o_keyReady   (o_keyReady),
        .o_busy       (o_busy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Key table and block datapath
    ////////////////////////////////////////////////////////////////////////////

    keySchedule keys (
        .clk         (clk),
        .i_key       (i_key),
        .i_capture   (keyCapture),
        .i_fill      (fill),
        .i_mix       (mix),
        .i_pairIndex (pairIndex),
        .o_keyEven   (keyEven),
        .o_keyOdd    (keyOdd)
    );

    roundDatapath datapath (
        .clk       (clk),
        .i_rstN    (i_rstN),
        .i_block   (i_block),
        .i_start   (blockLoad),
        .i_phase   (phase),
        .i_decrypt (decrypt),
        .i_keyEven (keyEven),
        .i_keyOdd  (keyOdd),
        .o_block   (o_block)
    );

endmodule

`default_nettype wire

// File: bench/rc5_chk.sv
`default_nettype none

// Protocol checks on the control outputs of the core
module rc5Chk (
    input wire clk,
    input wire i_rstN,
    input wire i_done,
    input wire i_busy,
    input wire i_keyReady
);

    int failCount = 0;

    // A done pulse lasts exactly one cycle
    donePulse: assert property (@(posedge clk) disable iff (!i_rstN) i_done |=> !i_done)
        else begin
            failCount++;
            $error("o_done stayed high for two cycles in a row");
        end

    // Done only closes a block that was running
    doneAfterBusy: assert property (@(posedge clk) disable iff (!i_rstN)
                                    $rose(i_done) |-> $past(i_busy))
        else begin
            failCount++;
            $error("o_done rose without o_busy high on the previous cycle");
        end

    // Control outputs are quiet right after a reset edge
    resetQuiet: assert property (@(posedge clk)
                                 !i_rstN |=> !(i_done || i_busy || i_keyReady))
        else begin
            failCount++;
            $error("Control outputs not low in the cycle after reset");
        end

endmodule

bind rc5Core rc5Chk chk (
    .clk        (clk),
    .i_rstN     (i_rstN),
    .i_done     (o_done),
    .i_busy     (o_busy),
    .i_keyReady (o_keyReady)
);

`default_nettype wire

// File: bench/rc5Tb.sv
`default_nettype none
`include "rc5_macros.svh"

module rc5Tb;

    localparam int ROWS = 8;
    localparam int KEY_CYCLES = `RC5_TABLE + `RC5_MIX_STEPS;
    localparam int BLOCK_CYCLES = `RC5_ROUNDS + 2;
    // Each row loads a key and runs two blocks with slack
    // Two extra rows cover the remaining tests
    localparam int CYCLE_LIMIT = (ROWS + 2) * (KEY_CYCLES + 2 * BLOCK_CYCLES + 20);

    logic                  clk = 1'b0;
    logic                  i_rstN;
    logic [`RC5_KEY-1:0]   i_key;
    logic                  i_keyLoad;
    logic [`RC5_BLOCK-1:0] i_block;
    logic                  i_decrypt;
    logic                  i_start;
    wire  [`RC5_BLOCK-1:0] o_block;
    wire                   o_done;
    wire                   o_keyReady;
    wire                   o_busy;

    // Stimulus table with the expected column filled by the model
    logic [`RC5_KEY-1:0]   keyTab   [ROWS];
    logic [`RC5_BLOCK-1:0] blockTab [ROWS];
    logic                  dirTab   [ROWS];
    logic [`RC5_BLOCK-1:0] expTab   [ROWS];
    logic [`RC5_WORD-1:0]  modelS   [`RC5_TABLE];

    int seed;
    int mismatches = 0;
    int otherErrors = 0;
    int cycles = 0;

    rc5Core UUT (
        .clk        (clk),
        .i_rstN     (i_rstN),
        .i_key      (i_key),
        .i_keyLoad  (i_keyLoad),
        .i_block    (i_block),
        .i_decrypt  (i_decrypt),
        .i_start    (i_start),
        .o_block    (o_block),
        .o_done     (o_done),
        .o_keyReady (o_keyReady),
        .o_busy     (o_busy)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Mismatches: %0d, other errors: %0d", mismatches, otherErrors + 1);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [`RC5_WORD-1:0] rotLeft(input logic [`RC5_WORD-1:0] x,
                                                     input logic [4:0] n);
        int amount;
        amount = int'(n);
        if (amount == 0) return x;
        return (x << amount) | (x >> (32 - amount));
    endfunction

    function automatic logic [`RC5_WORD-1:0] rotRight(input logic [`RC5_WORD-1:0] x,
                                                      input logic [4:0] n);
        int amount;
        amount = int'(n);
        if (amount == 0) return x;
        return (x >> amount) | (x << (32 - amount));
    endfunction

    task automatic expandKey(input logic [`RC5_KEY-1:0] key);
        logic [`RC5_WORD-1:0] l [`RC5_KEY_WORDS];
        logic [`RC5_WORD-1:0] a;
        logic [`RC5_WORD-1:0] b;
        logic [`RC5_WORD-1:0] sum;
        int i;
        int j;
        for (int k = 0; k < `RC5_KEY_WORDS; k++) begin
            l[k] = key[32*k +: 32];
        end
        modelS[0] = `RC5_P32;
        for (int k = 1; k < `RC5_TABLE; k++) begin
            modelS[k] = modelS[k-1] + `RC5_Q32;
        end
        a = '0;
        b = '0;
        i = 0;
        j = 0;
        for (int step = 0; step < `RC5_MIX_STEPS; step++) begin
            a = rotLeft(modelS[i] + a + b, 5'd3);
            modelS[i] = a;
            sum = a + b;
            b = rotLeft(l[j] + sum, sum[4:0]);
            l[j] = b;
            i = (i + 1) % `RC5_TABLE;
            j = (j + 1) % `RC5_KEY_WORDS;
        end
    endtask

    function automatic logic [`RC5_BLOCK-1:0] modelCipher(input logic [`RC5_BLOCK-1:0] blk,
                                                          input logic decrypt);
        rc5Pkg::blockT v;
        v.flat = blk;
        if (!decrypt) begin
            v.half.a = v.half.a + modelS[0];
            v.half.b = v.half.b + modelS[1];
            for (int r = 1; r <= `RC5_ROUNDS; r++) begin
                v.half.a = rotLeft(v.half.a ^ v.half.b, v.half.b[4:0]) + modelS[2*r];
                v.half.b = rotLeft(v.half.b ^ v.half.a, v.half.a[4:0]) + modelS[2*r+1];
            end
        end else begin
            for (int r = `RC5_ROUNDS; r >= 1; r--) begin
                v.half.b = rotRight(v.half.b - modelS[2*r+1], v.half.a[4:0]) ^ v.half.a;
                v.half.a = rotRight(v.half.a - modelS[2*r], v.half.b[4:0]) ^ v.half.b;
            end
            v.half.b = v.half.b - modelS[1];
            v.half.a = v.half.a - modelS[0];
        end
        return v.flat;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [`RC5_BLOCK-1:0] expected,
                              input logic [`RC5_BLOCK-1:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic loadKey(input logic [`RC5_KEY-1:0] key);
        int waited;
        @(posedge clk);
        i_key     <= key;
        i_keyLoad <= 1'b1;
        @(posedge clk);
        i_keyLoad <= 1'b0;
        waited = 0;
        @(negedge clk);
        checkValue("key load busy", 64'(1), 64'(o_busy));
        checkValue("key load ready cleared", 64'(0), 64'(o_keyReady));
        while (!o_keyReady && waited < 2 * KEY_CYCLES) begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end
        if (!o_keyReady) begin
            otherErrors++;
            $display("Error: key expansion did not finish within %0d cycles", waited);
        end else begin
            checkValue("key expansion cycles", 64'(KEY_CYCLES), 64'(waited));
        end
    endtask

    // The wait counts edges after the start edge
    task automatic runBlock(input logic [`RC5_BLOCK-1:0] blk, input logic decrypt,
                            output logic [`RC5_BLOCK-1:0] res, output int waited);
        @(posedge clk);
        i_block   <= blk;
        i_decrypt <= decrypt;
        i_start   <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!o_done && waited < 3 * BLOCK_CYCLES) begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end
        res = o_block;
        if (!o_done) begin
            otherErrors++;
            $display("Error: no o_done within %0d cycles of the start edge", waited);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]           rnd;
        logic [`RC5_BLOCK-1:0] result;
        logic [`RC5_BLOCK-1:0] first;
        int                    latency;
        int                    dones;

        i_rstN    <= 1'b0;
        i_key     <= '0;
        i_keyLoad <= 1'b0;
        i_block   <= '0;
        i_decrypt <= 1'b0;
        i_start   <= 1'b0;
        seed = 32'h0884_8528;

        keyTab[0]   = '0;
        blockTab[0] = '0;
        dirTab[0]   = 1'b0;
        keyTab[1]   = '1;
        blockTab[1] = '1;
        dirTab[1]   = 1'b0;
        keyTab[2]   = 128'h0f0e0d0c_0b0a0908_07060504_03020100;
        blockTab[2] = 64'h01234567_89abcdef;
        dirTab[2]   = 1'b1;
        keyTab[3]   = {4{32'h5a5a_a5a5}};
        blockTab[3] = 64'hdeadbeef_00ff00ff;
        dirTab[3]   = 1'b0;
        for (int r = 4; r < ROWS; r++) begin
            keyTab[r]   = {$random(seed), $random(seed), $random(seed), $random(seed)};
            blockTab[r] = {$random(seed), $random(seed)};
            rnd         = $random(seed);
            dirTab[r]   = rnd[0];
        end

        // Published vector for the all-zero key and block
        expandKey('0);
        checkValue("model vector", 64'hEEDBA521_6D8F4B15, modelCipher('0, 1'b0));
        for (int r = 0; r < ROWS; r++) begin
            expandKey(keyTab[r]);
            expTab[r] = modelCipher(blockTab[r], dirTab[r]);
        end

        repeat (2) @(posedge clk);
        i_rstN <= 1'b1;
        @(negedge clk);
        checkValue("reset flags", 64'(0), 64'({o_done, o_busy, o_keyReady}));
        checkValue("reset block", 64'(0), o_block);

        // Start without a key must be ignored
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        dones = 0;
        repeat (20) begin
            @(negedge clk);
            dones = dones + int'(o_done) + int'(o_busy);
        end
        checkValue("start before key", 64'(0), 64'(dones));

        for (int r = 0; r < ROWS; r++) begin
            loadKey(keyTab[r]);
            runBlock(blockTab[r], dirTab[r], result, latency);
            checkValue($sformatf("row %0d result", r), expTab[r], result);
            checkValue($sformatf("row %0d latency", r), 64'(BLOCK_CYCLES), 64'(latency));
            runBlock(result, !dirTab[r], result, latency);
            checkValue($sformatf("row %0d round trip", r), blockTab[r], result);
            checkValue($sformatf("row %0d back latency", r), 64'(BLOCK_CYCLES), 64'(latency));
        end

        // Second start while the first block runs
        expandKey(keyTab[ROWS-1]);
        first = modelCipher(64'h00112233_44556677, 1'b0);
        @(posedge clk);
        i_block   <= 64'h00112233_44556677;
        i_decrypt <= 1'b0;
        i_start   <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        repeat (2) @(posedge clk);
        i_block <= 64'h8899aabb_ccddeeff;
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        dones = 0;
        result = '0;
        repeat (30) begin
            @(negedge clk);
            if (o_done) begin
                dones++;
                result = o_block;
            end
        end
        checkValue("busy start done count", 64'(1), 64'(dones));
        checkValue("busy start result", first, result);

        // New key with the same block
        expandKey(keyTab[2]);
        loadKey(keyTab[2]);
        runBlock(64'h00112233_44556677, 1'b0, result, latency);
        checkValue("reload result", modelCipher(64'h00112233_44556677, 1'b0), result);
        if (result === first) begin
            otherErrors++;
            $display("Error: ciphertext did not change after loading a new key");
        end

        // Reset in the middle of a block clears the ready key and the result
        @(posedge clk);
        i_block <= 64'h00112233_44556677;
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        repeat (3) @(posedge clk);
        i_rstN <= 1'b0;
        repeat (2) @(posedge clk);
        i_rstN <= 1'b1;
        @(negedge clk);
        checkValue("mid reset flags", 64'(0), 64'({o_done, o_busy, o_keyReady}));
        checkValue("mid reset block", 64'(0), o_block);

        repeat (2) @(posedge clk);
        otherErrors = otherErrors + UUT.chk.failCount;
        $display("Mismatches: %0d, other errors: %0d", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/rc5Pkg.sv
source/stepCounter.sv
source/rc5Control.sv
source/keySchedule.sv
source/roundDatapath.sv
source/rc5Core.sv
bench/rc5_chk.sv
bench/rc5Tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RC5 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module rc5Tb -o rc5Sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rc5Sim 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -qx ">>> PASS" "$LOG"
if [ $? -ne 0 ]; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
